// ==== logic/intra_pred_cfg.svh ====
// widths, counter loads and RAM layout for the intra prediction control path
// the RAM holds 44 luma words then 22 words each for Cb and Cr
`ifndef INTRA_PRED_CFG_SVH
`define INTRA_PRED_CFG_SVH

`define PIX_W          8
`define HV_W           15
`define COEF_W         12
`define A_W            14
`define SEED_W         16
`define RAM_AW         7

`define CB_BASE        7'd44
`define CR_BASE        7'd66

`define LUMA_PRELOAD   3'd5
`define CHROMA_PRELOAD 3'd3
`define LUMA_PRECOMP   4'd11
`define CHROMA_PRECOMP 4'd7
`define CALC_LOAD      3'd4
`define LAST_MB_H      4'd10

`endif

// ==== logic/intra_pred_pkg.sv ====
// shared sample, plane coefficient and prediction mode types
// mode encodings follow the H.264 syntax values
`include "intra_pred_cfg.svh"

package intra_pred_pkg;

	typedef logic [`PIX_W-1:0] pixel_t;
	typedef logic signed [`HV_W-1:0] hv_acc_t;
	typedef logic signed [`COEF_W-1:0] plane_coef_t;
	typedef logic [`A_W-1:0] plane_a_t;
	typedef logic signed [`SEED_W-1:0] seed_t;

	typedef enum logic [1:0] {
		L16_VERTICAL   = 2'd0,
		L16_HORIZONTAL = 2'd1,
		L16_DC         = 2'd2,
		L16_PLANE      = 2'd3
	} luma16_mode_t;

	typedef enum logic [1:0] {
		CHROMA_DC         = 2'd0,
		CHROMA_HORIZONTAL = 2'd1,
		CHROMA_VERTICAL   = 2'd2,
		CHROMA_PLANE      = 2'd3
	} chroma_mode_t;

endpackage

// ==== logic/intra_step_if.sv ====
// step counters and block class from the controller, no handshake
`timescale 1ns/1ps

interface intra_step_if;
	logic [2:0] preload_count;
	logic [3:0] precompute_count;
	// Intra16x16 block 0, or chroma block 16/20
	logic is_luma16_blk;
	logic is_chroma_blk;

	modport ctrl (output preload_count, precompute_count, is_luma16_blk, is_chroma_blk);
	modport reader (input preload_count, precompute_count, is_luma16_blk, is_chroma_blk);
endinterface

// ==== logic/plane_hv_unit.sv ====
// one H/V accumulation step: prev + w1*(a1-a2) + w2*(b1-b2)
// w1 in 1/2/4/8, w2 in 3/5/6/7 built from a shift and an add or subtract
`timescale 1ns/1ps
`include "intra_pred_cfg.svh"

module plane_hv_unit (
	input  intra_pred_pkg::hv_acc_t prev_in,
	input  intra_pred_pkg::pixel_t  a1,
	input  intra_pred_pkg::pixel_t  a2,
	input  intra_pred_pkg::pixel_t  b1,
	input  intra_pred_pkg::pixel_t  b2,
	input  logic [1:0]              shift1_len,
	input  logic [1:0]              shift2_len,
	input  logic                    mux1_sel,
	input  logic                    mux2_sel,
	input  logic                    is_seven,
	output intra_pred_pkg::hv_acc_t hv_out
);

	logic signed [8:0] diff_a, diff_b;
	logic signed [11:0] da_w, db_w;
	logic signed [11:0] left_term, shifted_b, base_b, right_term;

	assign diff_a = $signed({1'b0, a1}) - $signed({1'b0, a2});
	assign diff_b = $signed({1'b0, b1}) - $signed({1'b0, b2});
	assign da_w = {{3{diff_a[8]}}, diff_a};
	assign db_w = {{3{diff_b[8]}}, diff_b};

	assign left_term = mux1_sel ? (da_w <<< shift1_len) : da_w;

	// 3 = 2+1, 5 = 4+1, 6 = 4+2, 7 = 8-1
	assign shifted_b = db_w <<< shift2_len;
	assign base_b = mux2_sel ? (db_w <<< 1) : db_w;
	assign right_term = is_seven ? (shifted_b - base_b) : (shifted_b + base_b);

	assign hv_out = prev_in + {{(`HV_W-12){left_term[11]}}, left_term} +
		{{(`HV_W-12){right_term[11]}}, right_term};

endmodule

// ==== logic/plane_coef_unit.sv ====
// b/c scaling, a and the main seed for plane prediction
// chroma scaling (34H+32)>>6 equals the standard (17H+16)>>5
`timescale 1ns/1ps
`include "intra_pred_cfg.svh"

module plane_coef_unit (
	input  intra_pred_pkg::hv_acc_t     hv_in,
	input  logic                        is_luma,
	input  intra_pred_pkg::pixel_t      pix1,
	input  intra_pred_pkg::pixel_t      pix2,
	input  intra_pred_pkg::plane_a_t    seed_a,
	input  intra_pred_pkg::plane_coef_t seed_b,
	input  intra_pred_pkg::plane_coef_t seed_c,
	input  logic                        seed_luma,
	output intra_pred_pkg::plane_coef_t coef_out,
	output intra_pred_pkg::plane_a_t    a_out,
	output intra_pred_pkg::seed_t       seed_out
);

	logic signed [19:0] hv_wide, scaled, rounded;
	logic [8:0] pix_sum;
	logic signed [17:0] a_wide, b_wide, c_wide, seed_wide;

	assign hv_wide = {{(20-`HV_W){hv_in[`HV_W-1]}}, hv_in};
	assign scaled = is_luma ? (hv_wide * 20'sd5) : (hv_wide * 20'sd34);
	assign rounded = (scaled + 20'sd32) >>> 6;
	assign coef_out = rounded[`COEF_W-1:0];

	// a = 16 * (left[last] + top[last])
	assign pix_sum = {1'b0, pix1} + {1'b0, pix2};
	assign a_out = {1'b0, pix_sum, 4'b0000};

	assign a_wide = $signed({4'b0000, seed_a});
	assign b_wide = {{(18-`COEF_W){seed_b[`COEF_W-1]}}, seed_b};
	assign c_wide = {{(18-`COEF_W){seed_c[`COEF_W-1]}}, seed_c};

	// seed is the prediction origin, a - 7b - 8c or a - 3b - 4c
	assign seed_wide = seed_luma ? (a_wide - b_wide * 18'sd7 - (c_wide <<< 3)) :
		(a_wide - b_wide * 18'sd3 - (c_wide <<< 2));
	assign seed_out = seed_wide[`SEED_W-1:0];

endmodule

// ==== logic/intra_step_ctrl.sv ====
// mb_type[3] marks intra, mb_type[3:2] == 2'b10 marks Intra16x16
// Intra4x4 luma blocks use the plain trigger rule for the calculate counter
`timescale 1ns/1ps
`include "intra_pred_cfg.svh"

module intra_step_ctrl (
	input  logic                         clk,
	input  logic                         reset_n,
	input  logic [3:0]                   mb_type,
	input  logic [4:0]                   blk_counter,
	input  logic                         trigger,
	input  logic [3:0]                   mb_num_v,
	input  logic [3:0]                   mb_num_h,
	input  intra_pred_pkg::luma16_mode_t luma16_mode,
	input  intra_pred_pkg::chroma_mode_t chroma_mode,
	output logic [2:0]                   calculate_count,
	output logic                         end_of_blk,
	output logic                         mb_a_avail,
	output logic                         mb_b_avail,
	output logic                         mb_c_avail,
	intra_step_if.ctrl                   step
);

	logic chroma_sel;
	logic mode_plane;
	logic mode_preload;
	logic precomp_load;
	logic calc_load;

	// neighbour macroblocks
	assign mb_a_avail = mb_type[3] && (mb_num_h != 4'd0);
	assign mb_b_avail = mb_type[3] && (mb_num_v != 4'd0);
	assign mb_c_avail = mb_b_avail && (mb_num_h != `LAST_MB_H);

	assign step.is_luma16_blk = (mb_type[3:2] == 2'b10) && (blk_counter == 5'd0);
	assign step.is_chroma_blk = (blk_counter == 5'd16) || (blk_counter == 5'd20);
	assign chroma_sel = mb_type[3] && step.is_chroma_blk;

	// which step sequence the current block runs
	always_comb
	begin
		mode_plane = 1'b0;
		mode_preload = 1'b0;
		if (step.is_luma16_blk)
		begin
			mode_plane = (luma16_mode == intra_pred_pkg::L16_PLANE);
			mode_preload = mode_plane || (luma16_mode == intra_pred_pkg::L16_VERTICAL) ||
				((luma16_mode == intra_pred_pkg::L16_DC) && mb_b_avail);
		end
		else if (chroma_sel)
		begin
			mode_plane = (chroma_mode == intra_pred_pkg::CHROMA_PLANE);
			mode_preload = mode_plane || (chroma_mode == intra_pred_pkg::CHROMA_VERTICAL) ||
				((chroma_mode == intra_pred_pkg::CHROMA_DC) && mb_b_avail);
		end
	end

	assign precomp_load = mode_plane && (step.preload_count == 3'd1);

	// plane waits for the seed, other preload modes for the last upper read
	always_comb
	begin
		if (mode_plane)
			calc_load = (step.precompute_count == 4'd1);
		else if (mode_preload)
			calc_load = (step.preload_count == 3'd1);
		else
			calc_load = trigger;
	end

	//--------------------
	// step counters
	//--------------------
	always_ff @(posedge clk)
	begin
		if (!reset_n)
		begin
			step.preload_count <= 3'd0;
			step.precompute_count <= 4'd0;
			calculate_count <= 3'd0;
		end
		else
		begin
			if (trigger)
				step.preload_count <= !mode_preload ? 3'd0 :
					(step.is_luma16_blk ? `LUMA_PRELOAD : `CHROMA_PRELOAD);
			else if (step.preload_count != 3'd0)
				step.preload_count <= step.preload_count - 3'd1;

			if (precomp_load)
				step.precompute_count <= step.is_luma16_blk ? `LUMA_PRECOMP : `CHROMA_PRECOMP;
			else if (step.precompute_count != 4'd0)
				step.precompute_count <= step.precompute_count - 4'd1;

			if (calc_load)
				calculate_count <= `CALC_LOAD;
			else if (calculate_count != 3'd0)
				calculate_count <= calculate_count - 3'd1;
		end
	end

	assign end_of_blk = (calculate_count == 3'd1);

	// plane precompute starts only once the previous block has finished
	a_precomp_after_calc: assert property (@(posedge clk) disable iff (!reset_n)
		precomp_load |-> (calculate_count == 3'd0))
		else $error("precompute counter loaded while calculate counter busy");

endmodule

// ==== logic/nbr_read_addr.sv ====
// read port of the upper-neighbour RAM, combinational from the step state
// address is zero whenever no read is requested
`timescale 1ns/1ps
`include "intra_pred_cfg.svh"

module nbr_read_addr (
	input  logic [4:0]          blk_counter,
	input  logic [2:0]          sum_counter,
	input  logic [3:0]          mb_num_v,
	input  logic [3:0]          mb_num_h,
	input  logic                next_mb_is_skip,
	input  logic                mb_b_avail,
	intra_step_if.reader        step,
	output logic                nbr_rd,
	output logic [`RAM_AW-1:0]  nbr_rd_addr
);

	logic is_luma;
	logic preload_rd;
	logic prefetch;
	logic [`RAM_AW-1:0] base;
	logic [`RAM_AW-1:0] shift;
	logic [`RAM_AW-1:0] index;

	assign is_luma = (blk_counter < 5'd16);
	assign preload_rd = (step.preload_count >= 3'd2);

	// top-left pixel for the next macroblock, fetched in the last block of a component
	assign prefetch = (sum_counter == 3'd0) &&
		((blk_counter == 5'd15) || (blk_counter == 5'd19) || (blk_counter == 5'd23)) &&
		mb_b_avail && (mb_num_h != `LAST_MB_H) && !next_mb_is_skip;

	assign nbr_rd = preload_rd || prefetch;

	assign base = (blk_counter >= 5'd20) ? `CR_BASE :
		((blk_counter >= 5'd16) ? `CB_BASE : 7'd0);
	assign shift = is_luma ? {1'b0, mb_num_h, 2'b00} : {2'b00, mb_num_h, 1'b0};

	// luma preload walks words 0..3, chroma alternates 0 and 1
	always_comb
	begin
		if (preload_rd)
			index = is_luma ? {4'd0, 3'(`LUMA_PRELOAD - step.preload_count)} :
				{6'd0, ~step.preload_count[0]};
		else
			index = is_luma ? 7'd3 : 7'd1;
	end

	assign nbr_rd_addr = nbr_rd ? (base + shift + index) : '0;

	always_comb
	begin
		assert (!(preload_rd && prefetch))
			else $error("preload read and top-left prefetch in the same cycle");
		assert (!prefetch || (mb_num_v != 4'd0))
			else $error("top-left prefetch in the first macroblock row");
	end

endmodule

// ==== logic/plane_precompute.sv ====
// plane parameters over the precompute count: V pass, c, H pass, a and b, seed
// luma uses counts 11..1, chroma 7..1; counts outside these leave the registers alone
`timescale 1ns/1ps

module plane_precompute (
	input  logic                        clk,
	input  logic                        reset_n,
	input  intra_pred_pkg::pixel_t      left_pels [16],
	input  intra_pred_pkg::pixel_t      top_pels [16],
	input  intra_pred_pkg::pixel_t      corner_pel,
	intra_step_if.reader                step,
	output intra_pred_pkg::plane_coef_t plane_b,
	output intra_pred_pkg::plane_coef_t plane_c,
	output intra_pred_pkg::seed_t       main_seed
);

	logic [3:0] cnt;
	logic is_luma;
	logic use_left;
	logic hv_active;
	logic [1:0] stage;
	logic [3:0] ia1, ia2, ib1, ib2;
	logic [1:0] sh1, sh2;
	logic m1, m2, s7;
	intra_pred_pkg::pixel_t src [16];
	intra_pred_pkg::pixel_t hv_a2, hv_b2, pix1, pix2;
	intra_pred_pkg::hv_acc_t hv_prev, hv_out, hv_reg;
	intra_pred_pkg::plane_coef_t coef;
	intra_pred_pkg::plane_a_t a_val, a_reg;
	intra_pred_pkg::seed_t seed_val;

	assign cnt = step.precompute_count;
	assign is_luma = step.is_luma16_blk;

	// left column first (V), then top row (H)
	always_comb
	begin
		use_left = 1'b0;
		hv_active = 1'b0;
		stage = 2'd0;
		if (is_luma)
		begin
			use_left = (cnt >= 4'd8);
			hv_active = (cnt >= 4'd3) && (cnt != 4'd7);
			stage = use_left ? 2'(4'd11 - cnt) : 2'(4'd6 - cnt);
		end
		else if (step.is_chroma_blk)
		begin
			use_left = (cnt >= 4'd6);
			hv_active = (cnt >= 4'd3) && (cnt != 4'd5);
			stage = use_left ? 2'(4'd7 - cnt) : 2'(4'd4 - cnt);
		end
	end

	// pixel pairs and weights per stage: {a1, a2, b1, b2}, {sh1, sh2, m1, m2, s7}
	always_comb
	begin
		for (int i = 0; i < 16; i++)
			src[i] = use_left ? left_pels[i] : top_pels[i];
		case ({is_luma, stage})
			3'b100:
			begin
				{ia1, ia2, ib1, ib2} = {4'd8, 4'd6, 4'd10, 4'd4};
				{sh1, sh2, m1, m2, s7} = {2'd0, 2'd1, 1'b0, 1'b0, 1'b0};
			end
			3'b101:
			begin
				{ia1, ia2, ib1, ib2} = {4'd9, 4'd5, 4'd12, 4'd2};
				{sh1, sh2, m1, m2, s7} = {2'd1, 2'd2, 1'b1, 1'b0, 1'b0};
			end
			3'b110:
			begin
				{ia1, ia2, ib1, ib2} = {4'd11, 4'd3, 4'd13, 4'd1};
				{sh1, sh2, m1, m2, s7} = {2'd2, 2'd2, 1'b1, 1'b1, 1'b0};
			end
			// x=7 pair reaches the corner, weight 7 as 8-1
			3'b111:
			begin
				{ia1, ia2, ib1, ib2} = {4'd15, 4'd0, 4'd14, 4'd0};
				{sh1, sh2, m1, m2, s7} = {2'd3, 2'd3, 1'b1, 1'b0, 1'b1};
			end
			3'b000:
			begin
				{ia1, ia2, ib1, ib2} = {4'd4, 4'd2, 4'd6, 4'd0};
				{sh1, sh2, m1, m2, s7} = {2'd0, 2'd1, 1'b0, 1'b0, 1'b0};
			end
			3'b001:
			begin
				{ia1, ia2, ib1, ib2} = {4'd5, 4'd1, 4'd7, 4'd0};
				{sh1, sh2, m1, m2, s7} = {2'd1, 2'd1, 1'b1, 1'b1, 1'b0};
			end
			default:
			begin
				{ia1, ia2, ib1, ib2} = '0;
				{sh1, sh2, m1, m2, s7} = '0;
			end
		endcase
	end

	assign hv_a2 = (is_luma && (stage == 2'd3)) ? corner_pel : src[ia2];
	assign hv_b2 = (!is_luma && (stage == 2'd1)) ? corner_pel : src[ib2];
	assign hv_prev = (stage == 2'd0) ? '0 : hv_reg;

	plane_hv_unit u_hv (
		.prev_in    (hv_prev),
		.a1         (src[ia1]),
		.a2         (hv_a2),
		.b1         (src[ib1]),
		.b2         (hv_b2),
		.shift1_len (sh1),
		.shift2_len (sh2),
		.mux1_sel   (m1),
		.mux2_sel   (m2),
		.is_seven   (s7),
		.hv_out     (hv_out)
	);

	assign pix1 = is_luma ? left_pels[15] : left_pels[7];
	assign pix2 = is_luma ? top_pels[15] : top_pels[7];

	plane_coef_unit u_coef (
		.hv_in     (hv_reg),
		.is_luma   (is_luma),
		.pix1      (pix1),
		.pix2      (pix2),
		.seed_a    (a_reg),
		.seed_b    (plane_b),
		.seed_c    (plane_c),
		.seed_luma (is_luma),
		.coef_out  (coef),
		.a_out     (a_val),
		.seed_out  (seed_val)
	);

	always_ff @(posedge clk)
	begin
		if (hv_active)
			hv_reg <= hv_out;
		if (cnt == 4'd2)
			a_reg <= a_val;
	end

	always_ff @(posedge clk)
	begin
		if (!reset_n)
		begin
			plane_b <= '0;
			plane_c <= '0;
		end
		else
		begin
			if ((is_luma && (cnt == 4'd7)) || (step.is_chroma_blk && (cnt == 4'd5)))
				plane_c <= coef;
			if (cnt == 4'd2)
				plane_b <= coef;
		end
	end

	assign main_seed = (cnt == 4'd1) ? seed_val : '0;

endmodule

// ==== logic/intra_pred_ctrl_top.sv ====
// intra prediction control top: step counters, neighbour RAM read port, plane parameters
// trigger is a single-cycle strobe, one block at a time
`timescale 1ns/1ps
`include "intra_pred_cfg.svh"

module intra_pred_ctrl_top (
	input  logic                         clk,
	input  logic                         reset_n,
	input  logic [3:0]                   mb_type,
	input  logic [4:0]                   blk_counter,
	input  logic                         trigger,
	input  logic [3:0]                   mb_num_v,
	input  logic [3:0]                   mb_num_h,
	input  logic [2:0]                   sum_counter,
	input  logic                         next_mb_is_skip,
	input  intra_pred_pkg::luma16_mode_t luma16_mode,
	input  intra_pred_pkg::chroma_mode_t chroma_mode,
	input  intra_pred_pkg::pixel_t       left_pels [16],
	input  intra_pred_pkg::pixel_t       top_pels [16],
	input  intra_pred_pkg::pixel_t       corner_pel,
	output logic [2:0]                   preload_count,
	output logic [3:0]                   precompute_count,
	output logic [2:0]                   calculate_count,
	output logic                         end_of_blk,
	output logic                         mb_a_avail,
	output logic                         mb_b_avail,
	output logic                         mb_c_avail,
	output intra_pred_pkg::seed_t        main_seed,
	output intra_pred_pkg::plane_coef_t  plane_b,
	output intra_pred_pkg::plane_coef_t  plane_c,
	output logic                         nbr_rd,
	output logic [`RAM_AW-1:0]           nbr_rd_addr
);

	intra_step_if step_bus ();

	assign preload_count = step_bus.preload_count;
	assign precompute_count = step_bus.precompute_count;

	intra_step_ctrl u_ctrl (
		.clk             (clk),
		.reset_n         (reset_n),
		.mb_type         (mb_type),
		.blk_counter     (blk_counter),
		.trigger         (trigger),
		.mb_num_v        (mb_num_v),
		.mb_num_h        (mb_num_h),
		.luma16_mode     (luma16_mode),
		.chroma_mode     (chroma_mode),
		.calculate_count (calculate_count),
		.end_of_blk      (end_of_blk),
		.mb_a_avail      (mb_a_avail),
		.mb_b_avail      (mb_b_avail),
		.mb_c_avail      (mb_c_avail),
		.step            (step_bus)
	);

	nbr_read_addr u_nbr_rd (
		.blk_counter     (blk_counter),
		.sum_counter     (sum_counter),
		.mb_num_v        (mb_num_v),
		.mb_num_h        (mb_num_h),
		.next_mb_is_skip (next_mb_is_skip),
		.mb_b_avail      (mb_b_avail),
		.step            (step_bus),
		.nbr_rd          (nbr_rd),
		.nbr_rd_addr     (nbr_rd_addr)
	);

	plane_precompute u_plane (
		.clk        (clk),
		.reset_n    (reset_n),
		.left_pels  (left_pels),
		.top_pels   (top_pels),
		.corner_pel (corner_pel),
		.step       (step_bus),
		.plane_b    (plane_b),
		.plane_c    (plane_c),
		.main_seed  (main_seed)
	);

endmodule

// ==== verification/tb_clock_gen.sv ====
// free-running testbench clock, starts low
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter real PERIOD_NS = 40.0
) (
	output logic clk
);

	initial
	begin
		clk = 1'b0;
		forever
			#(PERIOD_NS / 2.0) clk = ~clk;
	end

endmodule

// ==== verification/tb_intra_pred.sv ====
// random blocks from a fixed seed, checked every cycle against a model of the step counters,
// the neighbour read port and the plane parameters; one block runs at a time
`timescale 1ns/1ps

module tb_intra_pred;

	localparam int BLK_TIMEOUT = 40;

	logic clk;
	logic reset_n;
	logic [3:0] mb_type;
	logic [4:0] blk_counter;
	logic trigger;
	logic [3:0] mb_num_v;
	logic [3:0] mb_num_h;
	logic [2:0] sum_counter;
	logic next_mb_is_skip;
	intra_pred_pkg::luma16_mode_t luma16_mode;
	intra_pred_pkg::chroma_mode_t chroma_mode;
	intra_pred_pkg::pixel_t left_pels [16];
	intra_pred_pkg::pixel_t top_pels [16];
	intra_pred_pkg::pixel_t corner_pel;
	logic [2:0] preload_count;
	logic [3:0] precompute_count;
	logic [2:0] calculate_count;
	logic end_of_blk;
	logic mb_a_avail;
	logic mb_b_avail;
	logic mb_c_avail;
	intra_pred_pkg::seed_t main_seed;
	intra_pred_pkg::plane_coef_t plane_b;
	intra_pred_pkg::plane_coef_t plane_c;
	logic nbr_rd;
	logic [6:0] nbr_rd_addr;

	// model state and expected plane results
	logic [2:0] m_pre;
	logic [3:0] m_pc;
	logic [2:0] m_calc;
	integer pl_b;
	integer pl_c;
	integer pl_seed;
	integer seed;
	integer pick;
	integer errors;
	integer timeouts;
	integer cycles;

	tb_clock_gen #(.PERIOD_NS(40.0)) u_clk (.clk(clk));

	intra_pred_ctrl_top u_dut (
		.clk              (clk),
		.reset_n          (reset_n),
		.mb_type          (mb_type),
		.blk_counter      (blk_counter),
		.trigger          (trigger),
		.mb_num_v         (mb_num_v),
		.mb_num_h         (mb_num_h),
		.sum_counter      (sum_counter),
		.next_mb_is_skip  (next_mb_is_skip),
		.luma16_mode      (luma16_mode),
		.chroma_mode      (chroma_mode),
		.left_pels        (left_pels),
		.top_pels         (top_pels),
		.corner_pel       (corner_pel),
		.preload_count    (preload_count),
		.precompute_count (precompute_count),
		.calculate_count  (calculate_count),
		.end_of_blk       (end_of_blk),
		.mb_a_avail       (mb_a_avail),
		.mb_b_avail       (mb_b_avail),
		.mb_c_avail       (mb_c_avail),
		.main_seed        (main_seed),
		.plane_b          (plane_b),
		.plane_c          (plane_c),
		.nbr_rd           (nbr_rd),
		.nbr_rd_addr      (nbr_rd_addr)
	);

	//--------------------
	// block class
	//--------------------
	function automatic logic is_luma16();
		return (mb_type[3:2] == 2'b10) && (blk_counter == 5'd0);
	endfunction

	function automatic logic is_chroma();
		return mb_type[3] && ((blk_counter == 5'd16) || (blk_counter == 5'd20));
	endfunction

	function automatic logic uses_plane();
		if (is_luma16())
			return luma16_mode == intra_pred_pkg::L16_PLANE;
		if (is_chroma())
			return chroma_mode == intra_pred_pkg::CHROMA_PLANE;
		return 1'b0;
	endfunction

	// vertical, DC with the top row, and plane read the upper neighbours first
	function automatic logic uses_preload();
		logic top;
		top = mb_type[3] && (mb_num_v != 4'd0);
		if (is_luma16())
			return (luma16_mode == intra_pred_pkg::L16_PLANE) ||
				(luma16_mode == intra_pred_pkg::L16_VERTICAL) ||
				((luma16_mode == intra_pred_pkg::L16_DC) && top);
		if (is_chroma())
			return (chroma_mode == intra_pred_pkg::CHROMA_PLANE) ||
				(chroma_mode == intra_pred_pkg::CHROMA_VERTICAL) ||
				((chroma_mode == intra_pred_pkg::CHROMA_DC) && top);
		return 1'b0;
	endfunction

	// sum of (x+1)*(p[n+x] - p[n-2-x]), index -1 is the corner pixel
	function automatic integer grad_sum(input logic from_left, input logic luma);
		integer n;
		integer s;
		integer x;
		integer hi;
		integer lo;
		n = luma ? 8 : 4;
		s = 0;
		for (x = 0; x < n; x++)
		begin
			hi = from_left ? integer'(left_pels[n + x]) : integer'(top_pels[n + x]);
			if (n - 2 - x < 0)
				lo = integer'(corner_pel);
			else
				lo = from_left ? integer'(left_pels[n - 2 - x]) : integer'(top_pels[n - 2 - x]);
			s = s + (x + 1) * (hi - lo);
		end
		return s;
	endfunction

	task automatic predict_plane();
		logic luma;
		integer h_sum;
		integer v_sum;
		integer scale;
		integer last;
		integer a_val;
		luma = (blk_counter < 5'd16);
		h_sum = grad_sum(1'b0, luma);
		v_sum = grad_sum(1'b1, luma);
		scale = luma ? 5 : 34;
		pl_b = (scale * h_sum + 32) >>> 6;
		pl_c = (scale * v_sum + 32) >>> 6;
		last = luma ? 15 : 7;
		a_val = 16 * (integer'(left_pels[last]) + integer'(top_pels[last]));
		pl_seed = luma ? (a_val - 7 * pl_b - 8 * pl_c) : (a_val - 3 * pl_b - 4 * pl_c);
	endtask

	// counters advance on the rising edge from the pre-edge state
	task automatic model_clock();
		logic [2:0] pre_q;
		logic [3:0] pc_q;
		logic calc_go;
		pre_q = m_pre;
		pc_q = m_pc;
		if (!reset_n)
		begin
			m_pre = 3'd0;
			m_pc = 4'd0;
			m_calc = 3'd0;
		end
		else
		begin
			if (trigger)
				m_pre = !uses_preload() ? 3'd0 : (is_luma16() ? 3'd5 : 3'd3);
			else if (pre_q != 3'd0)
				m_pre = pre_q - 3'd1;
			if (uses_plane() && (pre_q == 3'd1))
				m_pc = is_luma16() ? 4'd11 : 4'd7;
			else if (pc_q != 4'd0)
				m_pc = pc_q - 4'd1;
			if (uses_plane())
				calc_go = (pc_q == 4'd1);
			else if (uses_preload())
				calc_go = (pre_q == 3'd1);
			else
				calc_go = trigger;
			if (calc_go)
				m_calc = 3'd4;
			else if (m_calc != 3'd0)
				m_calc = m_calc - 3'd1;
		end
	endtask

	task automatic report_mismatch(input string name, input integer got, input integer expected);
		errors++;
		$display("MISMATCH at %0t: %s = %0d, expected %0d", $time, name, got, expected);
	endtask

	task automatic check_outputs();
		logic exp_av_a;
		logic exp_av_b;
		logic exp_av_c;
		logic exp_end;
		logic luma_blk;
		logic pre_rd;
		logic prefetch;
		logic exp_rd;
		integer base;
		integer idx;
		integer exp_addr;
		exp_av_a = mb_type[3] && (mb_num_h != 4'd0);
		exp_av_b = mb_type[3] && (mb_num_v != 4'd0);
		exp_av_c = exp_av_b && (mb_num_h != 4'd10);
		exp_end = (m_calc == 3'd1);
		luma_blk = (blk_counter < 5'd16);
		pre_rd = (m_pre >= 3'd2);
		// top-left prefetch in the last block of a component
		prefetch = (sum_counter == 3'd0) && ((blk_counter == 5'd15) || (blk_counter == 5'd19) ||
			(blk_counter == 5'd23)) && exp_av_b && (mb_num_h != 4'd10) && !next_mb_is_skip;
		exp_rd = pre_rd || prefetch;
		if (blk_counter >= 5'd20)
			base = 66;
		else if (blk_counter >= 5'd16)
			base = 44;
		else
			base = 0;
		if (pre_rd)
			idx = luma_blk ? (5 - integer'(m_pre)) : (m_pre[0] ? 0 : 1);
		else
			idx = luma_blk ? 3 : 1;
		exp_addr = base + (luma_blk ? 4 : 2) * integer'(mb_num_h) + idx;
		cycles++;
		if (mb_a_avail !== exp_av_a)
			report_mismatch("mb_a_avail", mb_a_avail, exp_av_a);
		if (mb_b_avail !== exp_av_b)
			report_mismatch("mb_b_avail", mb_b_avail, exp_av_b);
		if (mb_c_avail !== exp_av_c)
			report_mismatch("mb_c_avail", mb_c_avail, exp_av_c);
		if (preload_count !== m_pre)
			report_mismatch("preload_count", preload_count, m_pre);
		if (precompute_count !== m_pc)
			report_mismatch("precompute_count", precompute_count, m_pc);
		if (calculate_count !== m_calc)
			report_mismatch("calculate_count", calculate_count, m_calc);
		if (end_of_blk !== exp_end)
			report_mismatch("end_of_blk", end_of_blk, exp_end);
		if (nbr_rd !== exp_rd)
			report_mismatch("nbr_rd", nbr_rd, exp_rd);
		if (exp_rd && (nbr_rd_addr !== 7'(exp_addr)))
			report_mismatch("nbr_rd_addr", nbr_rd_addr, exp_addr);
		// plane results are all settled while the precompute count is 1
		if (m_pc == 4'd1)
		begin
			if (main_seed !== 16'(pl_seed))
				report_mismatch("main_seed", $signed(main_seed), pl_seed);
			if (plane_b !== 12'(pl_b))
				report_mismatch("plane_b", $signed(plane_b), pl_b);
			if (plane_c !== 12'(pl_c))
				report_mismatch("plane_c", $signed(plane_c), pl_c);
		end
		else if (main_seed !== 16'd0)
			report_mismatch("main_seed", $signed(main_seed), 0);
	endtask

	// inputs change only after the falling edge
	task automatic step_cycle();
		@(posedge clk);
		model_clock();
		@(negedge clk);
		check_outputs();
	endtask

	//--------------------
	// stimulus
	//--------------------
	task automatic randomize_position();
		integer r;
		r = $random(seed);
		mb_type = r[3:0];
		mb_num_v = (r[5:4] == 2'd0) ? 4'd0 : r[9:6];
		mb_num_h = 4'($unsigned($random(seed)) % 11);
		case (r[11:10])
			2'd0: blk_counter = 5'd15;
			2'd1: blk_counter = 5'd19;
			2'd2: blk_counter = 5'd23;
			default: blk_counter = r[22:18];
		endcase
		sum_counter = r[12] ? 3'd0 : r[15:13];
		next_mb_is_skip = r[16] && r[17];
	endtask

	task automatic setup_block(input logic chroma, input logic plane);
		integer r;
		integer i;
		r = $random(seed);
		blk_counter = !chroma ? 5'd0 : (r[0] ? 5'd20 : 5'd16);
		// Intra16x16 is 4'b10xx, Intra4x4 is 4'b11xx
		mb_type = {1'b1, (chroma || !plane) ? r[1] : 1'b0, r[3:2]};
		mb_num_v = 4'(r[5:4]);
		mb_num_h = 4'($unsigned($random(seed)) % 11);
		sum_counter = r[8:6];
		next_mb_is_skip = r[9];
		luma16_mode = plane ? intra_pred_pkg::L16_PLANE : intra_pred_pkg::luma16_mode_t'(r[11:10]);
		chroma_mode = plane ? intra_pred_pkg::CHROMA_PLANE :
			intra_pred_pkg::chroma_mode_t'(r[13:12]);
		corner_pel = 8'($random(seed));
		for (i = 0; i < 16; i++)
		begin
			left_pels[i] = 8'($random(seed));
			top_pels[i] = 8'($random(seed));
		end
	endtask

	task automatic run_block();
		integer waited;
		logic seen_end;
		predict_plane();
		trigger = 1'b1;
		step_cycle();
		trigger = 1'b0;
		waited = 0;
		seen_end = 1'b0;
		while (!seen_end && (waited < BLK_TIMEOUT))
		begin
			step_cycle();
			seen_end = (end_of_blk === 1'b1);
			waited++;
		end
		if (!seen_end)
		begin
			timeouts++;
			$display("ERROR at %0t: end_of_blk did not arrive within %0d cycles", $time,
				BLK_TIMEOUT);
		end
		// let the calculate counter drain to 0
		step_cycle();
	endtask

	initial
	begin
		seed = 25833;
		errors = 0;
		timeouts = 0;
		cycles = 0;
		m_pre = 3'd0;
		m_pc = 4'd0;
		m_calc = 3'd0;
		pl_b = 0;
		pl_c = 0;
		pl_seed = 0;
		reset_n = 1'b0;
		trigger = 1'b0;
		mb_type = 4'd0;
		blk_counter = 5'd0;
		mb_num_v = 4'd0;
		mb_num_h = 4'd0;
		sum_counter = 3'd0;
		next_mb_is_skip = 1'b0;
		luma16_mode = intra_pred_pkg::L16_VERTICAL;
		chroma_mode = intra_pred_pkg::CHROMA_DC;
		corner_pel = 8'd0;
		for (int i = 0; i < 16; i++)
		begin
			left_pels[i] = 8'd0;
			top_pels[i] = 8'd0;
		end

		repeat (2) step_cycle();
		reset_n = 1'b1;
		if (plane_b !== 12'd0)
			report_mismatch("plane_b", $signed(plane_b), 0);
		if (plane_c !== 12'd0)
			report_mismatch("plane_c", $signed(plane_c), 0);

		// availability and prefetch with idle counters
		repeat (80)
		begin
			randomize_position();
			step_cycle();
		end

		// random modes, luma or chroma
		repeat (24)
		begin
			pick = $random(seed);
			setup_block(pick[0], 1'b0);
			run_block();
		end

		repeat (8)
		begin
			setup_block(1'b0, 1'b1);
			run_block();
		end
		repeat (8)
		begin
			setup_block(1'b1, 1'b1);
			run_block();
		end

		$display("cycles checked %0d, errors %0d, timeouts %0d", cycles, errors, timeouts);
		if ((errors == 0) && (timeouts == 0))
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

// ==== files.f ====
+incdir+logic
logic/intra_pred_pkg.sv
logic/intra_step_if.sv
logic/plane_hv_unit.sv
logic/plane_coef_unit.sv
logic/intra_step_ctrl.sv
logic/nbr_read_addr.sv
logic/plane_precompute.sv
logic/intra_pred_ctrl_top.sv
verification/tb_clock_gen.sv
verification/tb_intra_pred.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the testbench with Verilator, run it, and judge the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f files.f --top-module tb_intra_pred
./obj_dir/Vtb_intra_pred | tee sim.log

if grep -q "Checks failed" sim.log
then
	echo "simulation FAILED"
	exit 1
fi
echo "simulation passed"
